// File: hw/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_xor,
        alu_and,
        alu_or,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [3:0] {
        class_alu_reg,
        class_alu_imm,
        class_lui,
        class_jal,
        class_jalr,
        class_branch,
        class_load,
        class_store,
        class_halt,
        class_illegal
    } insn_class_t;

    // immediate is already sign-extended and picked for the class
    typedef struct packed {
        insn_class_t insn_class;
        alu_op_t     alu_op;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        logic [2:0]  funct3;
        word_t       imm;
    } decoded_t;

    typedef enum logic [3:0] {
        state_init,
        state_fetch,
        state_fetch2,
        state_decode,
        state_execute,
        state_load,
        state_load2,
        state_store,
        state_retire,
        state_halted
    } state_t;

    // RV32I major opcodes
    localparam logic [6:0] opcode_lui     = 7'b0110111;
    localparam logic [6:0] opcode_jal     = 7'b1101111;
    localparam logic [6:0] opcode_jalr    = 7'b1100111;
    localparam logic [6:0] opcode_branch  = 7'b1100011;
    localparam logic [6:0] opcode_load    = 7'b0000011;
    localparam logic [6:0] opcode_store   = 7'b0100011;
    localparam logic [6:0] opcode_alu_imm = 7'b0010011;
    localparam logic [6:0] opcode_alu_reg = 7'b0110011;
    localparam logic [6:0] opcode_system  = 7'b1110011;

endpackage

// File: hw/reg_port_if.sv
`timescale 1ns/1ps

interface reg_port_if;
    import core_pkg::*;

    // read side, combinational
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // write side, takes effect on the clock edge
    logic      write;
    reg_addr_t rd_addr;
    word_t     rd_data;

    modport bank (
        input  rs1_addr, rs2_addr, write, rd_addr, rd_data,
        output rs1_data, rs2_data
    );

    modport core (
        output rs1_addr, rs2_addr, write, rd_addr, rd_data,
        input  rs1_data, rs2_data
    );

endinterface

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file (
    input logic      clock,
    reg_port_if.bank port
);
    import core_pkg::*;

    // x0 has no storage
    word_t bank [1:31];

    always_ff @(posedge clock) begin
        if (port.write && port.rd_addr != 5'd0) begin
            bank[port.rd_addr] <= port.rd_data;
        end
    end

    // x0 always reads as zero
    assign port.rs1_data = (port.rs1_addr == 5'd0) ? '0 : bank[port.rs1_addr];
    assign port.rs2_data = (port.rs2_addr == 5'd0) ? '0 : bank[port.rs2_addr];

    // the retire logic must never hand over an undefined result
    write_data_known: assert property (
        @(posedge clock) port.write |-> !$isunknown(port.rd_data)
    ) else $error("register write to x%0d with unknown data", port.rd_addr);

endmodule

// File: hw/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  core_pkg::word_t    instruction,
    output core_pkg::decoded_t decoded
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    arith_op;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    // bit 30 selects sub and sra
    assign alt    = instruction[30];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    // shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'd0:    arith_op = (opcode == opcode_alu_reg && alt) ? alu_sub : alu_add;
            3'd1:    arith_op = alu_sll;
            3'd2:    arith_op = alu_slt;
            3'd3:    arith_op = alu_sltu;
            3'd4:    arith_op = alu_xor;
            3'd5:    arith_op = alt ? alu_sra : alu_srl;
            3'd6:    arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        decoded.rs1        = instruction[19:15];
        decoded.rs2        = instruction[24:20];
        decoded.rd         = instruction[11:7];
        decoded.funct3     = funct3;
        decoded.alu_op     = alu_add;
        decoded.imm        = imm_i;
        decoded.insn_class = class_illegal;
        case (opcode)
            opcode_alu_reg: begin
                decoded.insn_class = class_alu_reg;
                decoded.alu_op     = arith_op;
            end
            opcode_alu_imm: begin
                decoded.insn_class = class_alu_imm;
                decoded.alu_op     = arith_op;
                // shift amount sits where the low immediate bits are
                if (funct3 == 3'd1 || funct3 == 3'd5) begin
                    decoded.imm = {27'b0, instruction[24:20]};
                end
            end
            opcode_lui: begin
                decoded.insn_class = class_lui;
                decoded.alu_op     = alu_pass_b;
                decoded.imm        = imm_u;
            end
            opcode_jal: begin
                decoded.insn_class = class_jal;
                decoded.imm        = imm_j;
            end
            opcode_jalr:   decoded.insn_class = class_jalr;
            opcode_branch: begin
                decoded.insn_class = class_branch;
                decoded.imm        = imm_b;
            end
            opcode_load:   decoded.insn_class = class_load;
            opcode_store: begin
                decoded.insn_class = class_store;
                decoded.imm        = imm_s;
            end
            // only the halt form of the system opcode is supported
            opcode_system: begin
                decoded.insn_class = (instruction[31:20] == 12'd1) ? class_halt : class_illegal;
            end
            default:       decoded.insn_class = class_illegal;
        endcase
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  core_pkg::decoded_t decoded,
    input  core_pkg::word_t    pc,
    input  core_pkg::word_t    rs1_data,
    input  core_pkg::word_t    rs2_data,
    output core_pkg::word_t    result,
    output logic               branch_taken
);
    import core_pkg::*;

    word_t operand_a;
    word_t operand_b;
    logic  is_shift;

    assign is_shift = decoded.alu_op inside {alu_sll, alu_srl, alu_sra};

    // jal and branch targets are pc relative
    assign operand_a = (decoded.insn_class inside {class_jal, class_branch}) ? pc : rs1_data;

    // register shifts use only the low five bits of rs2
    always_comb begin
        if (decoded.insn_class == class_alu_reg) begin
            operand_b = is_shift ? {27'b0, rs2_data[4:0]} : rs2_data;
        end else begin
            operand_b = decoded.imm;
        end
    end

    always_comb begin
        case (decoded.alu_op)
            alu_add:    result = operand_a + operand_b;
            alu_sub:    result = operand_a - operand_b;
            alu_sll:    result = operand_a << operand_b;
            alu_srl:    result = operand_a >> operand_b;
            alu_sra:    result = word_t'($signed(operand_a) >>> operand_b);
            alu_xor:    result = operand_a ^ operand_b;
            alu_and:    result = operand_a & operand_b;
            alu_or:     result = operand_a | operand_b;
            alu_slt:    result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            alu_sltu:   result = {31'b0, operand_a < operand_b};
            alu_pass_b: result = operand_b;
            default:    result = '0;
        endcase
    end

    // branch compares always use the register values
    always_comb begin
        case (decoded.funct3)
            3'd0:    branch_taken = rs1_data == rs2_data;
            3'd1:    branch_taken = rs1_data != rs2_data;
            3'd4:    branch_taken = $signed(rs1_data) < $signed(rs2_data);
            3'd5:    branch_taken = $signed(rs1_data) >= $signed(rs2_data);
            3'd6:    branch_taken = rs1_data < rs2_data;
            3'd7:    branch_taken = rs1_data >= rs2_data;
            default: branch_taken = 1'b0;
        endcase
        if (decoded.insn_class != class_branch) begin
            branch_taken = 1'b0;
        end
    end

    // decoder must only hand over defined operations for a legal word
    always_comb begin
        if (decoded.insn_class != class_illegal) begin
            assert (decoded.alu_op inside {[alu_add:alu_pass_b]})
                else $error("alu operation %0d outside the defined set", decoded.alu_op);
        end
    end

endmodule

// File: hw/control_fsm.sv
`timescale 1ns/1ps

module control_fsm #(
    parameter int address_width = 16
) (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     run,
    input  core_pkg::decoded_t       decoded,
    input  core_pkg::word_t          alu_result,
    input  logic                     branch_taken,
    input  core_pkg::word_t          rs2_data,
    input  core_pkg::word_t          inst_ram_read_result,
    input  core_pkg::word_t          data_ram_read_result,
    output core_pkg::word_t          instruction,
    output core_pkg::word_t          pc,
    output logic                     rd_write,
    output core_pkg::reg_addr_t      rd_addr,
    output core_pkg::word_t          rd_data,
    output logic [address_width-1:0] inst_ram_address,
    output logic [address_width-1:0] data_ram_address,
    output core_pkg::word_t          data_ram_write_data,
    output logic                     data_ram_write,
    output logic                     halted,
    output logic                     exception
);
    import core_pkg::*;

    state_t state;
    word_t  next_pc;
    logic   writes_rd;
    logic   is_jump;

    assign is_jump   = decoded.insn_class inside {class_jal, class_jalr};
    assign writes_rd = decoded.insn_class inside {class_alu_reg, class_alu_imm, class_lui,
                                                  class_jal, class_jalr, class_load};

    // target of jal/jalr is forced to even
    always_comb begin
        if (is_jump) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (branch_taken) begin
            next_pc = alu_result;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // register write happens at the edge that ends retire
    assign rd_write = run && (state == state_retire) && writes_rd;
    assign rd_addr  = decoded.rd;
    assign rd_data  = is_jump ? pc + 32'd4 :
                      (decoded.insn_class == class_load) ? data_ram_read_result :
                      alu_result;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state            <= state_init;
            pc               <= '0;
            inst_ram_address <= '0;
            data_ram_write   <= 1'b0;
            halted           <= 1'b0;
            exception        <= 1'b0;
        end else if (run) begin
            case (state)
                state_init: begin
                    pc    <= '0;
                    state <= state_fetch;
                end
                state_fetch: begin
                    inst_ram_address <= pc[address_width-1:0];
                    state            <= state_fetch2;
                end
                // memory answers during fetch2
                state_fetch2:  state <= state_decode;
                state_decode:  state <= state_execute;
                state_execute: begin
                    if (decoded.insn_class inside {class_halt, class_illegal}) begin
                        halted    <= 1'b1;
                        exception <= decoded.insn_class == class_illegal;
                        state     <= state_halted;
                    end else if (decoded.insn_class == class_load) begin
                        state <= state_load;
                    end else if (decoded.insn_class == class_store) begin
                        state <= state_store;
                    end else begin
                        state <= state_retire;
                    end
                end
                state_load:  state <= state_load2;
                state_load2: state <= state_retire;
                state_store: begin
                    data_ram_write <= 1'b1;
                    state          <= state_retire;
                end
                state_retire: begin
                    data_ram_write <= 1'b0;
                    pc             <= next_pc;
                    state          <= state_fetch;
                end
                state_halted: state <= state_halted;
                default:      state <= state_init;
            endcase
        end
    end

    // instruction latch and memory payload
    always_ff @(posedge clock) begin
        if (run) begin
            case (state)
                state_decode: instruction <= inst_ram_read_result;
                state_load:   data_ram_address <= alu_result[address_width-1:0];
                state_store: begin
                    data_ram_address    <= alu_result[address_width-1:0];
                    data_ram_write_data <= rs2_data;
                end
                default: begin
                end
            endcase
        end
    end

    write_single_cycle: assert property (
        @(posedge clock) disable iff (!reset_n) data_ram_write && run |=> !data_ram_write
    ) else $error("data_ram_write high for more than one running cycle");

    halted_sticky: assert property (
        @(posedge clock) halted && reset_n |=> halted
    ) else $error("halted dropped without a reset");

endmodule

// File: hw/shader_core.sv
`timescale 1ns/1ps

module shader_core #(
    parameter int address_width = 16
) (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     run,
    input  core_pkg::word_t          inst_ram_read_result,
    input  core_pkg::word_t          data_ram_read_result,
    output logic                     halted,
    output logic                     exception,
    output logic [address_width-1:0] inst_ram_address,
    output logic [address_width-1:0] data_ram_address,
    output core_pkg::word_t          data_ram_write_data,
    output logic                     data_ram_write
);
    import core_pkg::*;

    word_t     instruction;
    decoded_t  decoded;
    word_t     pc;
    word_t     alu_result;
    logic      branch_taken;
    logic      rd_write;
    reg_addr_t rd_addr;
    word_t     rd_data;

    reg_port_if reg_port ();

    // register addresses come straight from the decoded word
    assign reg_port.rs1_addr = decoded.rs1;
    assign reg_port.rs2_addr = decoded.rs2;
    assign reg_port.write    = rd_write;
    assign reg_port.rd_addr  = rd_addr;
    assign reg_port.rd_data  = rd_data;

    register_file u_register_file (
        .clock (clock),
        .port  (reg_port.bank)
    );

    decoder u_decoder (
        .instruction (instruction),
        .decoded     (decoded)
    );

    alu u_alu (
        .decoded      (decoded),
        .pc           (pc),
        .rs1_data     (reg_port.rs1_data),
        .rs2_data     (reg_port.rs2_data),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    control_fsm #(
        .address_width (address_width)
    ) u_control_fsm (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .decoded              (decoded),
        .alu_result           (alu_result),
        .branch_taken         (branch_taken),
        .rs2_data             (reg_port.rs2_data),
        .inst_ram_read_result (inst_ram_read_result),
        .data_ram_read_result (data_ram_read_result),
        .instruction          (instruction),
        .pc                   (pc),
        .rd_write             (rd_write),
        .rd_addr              (rd_addr),
        .rd_data              (rd_data),
        .inst_ram_address     (inst_ram_address),
        .data_ram_address     (data_ram_address),
        .data_ram_write_data  (data_ram_write_data),
        .data_ram_write       (data_ram_write),
        .halted               (halted),
        .exception            (exception)
    );

endmodule

// File: tests/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int address_width = 16
) (
    input  logic                     clock,
    input  logic [address_width-1:0] inst_address,
    output core_pkg::word_t          inst_data,
    input  logic [address_width-1:0] data_address,
    input  logic                     data_write,
    input  core_pkg::word_t          data_write_data,
    output core_pkg::word_t          data_read_data
);
    import core_pkg::*;

    // 256 words each, byte address bits [9:2] pick the word
    word_t inst_array [0:255];
    word_t data_array [0:255];

    initial begin
        inst_data      = '0;
        data_read_data = '0;
        for (int i = 0; i < 256; i++) begin
            // opcode field stays zero, so a stray fetch decodes as illegal
            inst_array[i] = {8'(i), 24'h000000};
            data_array[i] = {8'hda, 8'(i), ~8'(i), 8'h5a};
        end
    end

    // registered read, one cycle after the address changes
    always @(posedge clock) begin
        inst_data      <= inst_array[inst_address[9:2]];
        data_read_data <= data_array[data_address[9:2]];
        if (data_write) begin
            data_array[data_address[9:2]] <= data_write_data;
        end
    end

endmodule

// File: tests/tb_shader_core.sv
`timescale 1ns/1ps

module tb_shader_core;
    import core_pkg::*;

    localparam int address_width = 16;
    localparam int gap_cycles    = 20;
    // results land here, one word apart
    localparam int store_base    = 32'h100;

    logic                     clock = 1'b0;
    logic                     reset_n;
    logic                     run;
    logic                     halted;
    logic                     exception;
    logic [address_width-1:0] inst_ram_address;
    logic [address_width-1:0] data_ram_address;
    word_t                    inst_ram_read_result;
    word_t                    data_ram_read_result;
    word_t                    data_ram_write_data;
    logic                     data_ram_write;

    integer seed;
    int     errors = 0;
    int     cycle_count = 0;
    int     cycle_limit = 1000;
    int     program_length = 0;
    int     store_count = 0;
    int     store_index = 0;
    logic   expect_exception;
    logic   skipped [0:255];
    word_t  model_reg [0:31];
    logic [address_width-1:0] expected_address [0:63];
    word_t  expected_data [0:63];

    shader_core #(.address_width(address_width)) dut (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .inst_ram_read_result (inst_ram_read_result),
        .data_ram_read_result (data_ram_read_result),
        .halted               (halted),
        .exception            (exception),
        .inst_ram_address     (inst_ram_address),
        .data_ram_address     (data_ram_address),
        .data_ram_write_data  (data_ram_write_data),
        .data_ram_write       (data_ram_write)
    );

    data_memory #(.address_width(address_width)) mem (
        .clock           (clock),
        .inst_address    (inst_ram_address),
        .inst_data       (inst_ram_read_result),
        .data_address    (data_ram_address),
        .data_write      (data_ram_write),
        .data_write_data (data_ram_write_data),
        .data_read_data  (data_ram_read_result)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: halted not seen within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // a store is taken at the first running edge while the write is up
    always @(posedge clock) begin
        if (reset_n && run && data_ram_write) begin
            store_index <= store_index + 1;
        end
    end

    reset_address: assert property (@(posedge clock) !reset_n |=> inst_ram_address == '0)
        else begin
            errors++;
            $display("Mismatch at %0t: inst_ram_address expected 0, got %h",
                     $time, $sampled(inst_ram_address));
        end

    reset_status: assert property (
        @(posedge clock) !reset_n |=> {halted, exception, data_ram_write} == 3'b000
    ) else begin
        errors++;
        $display("Mismatch at %0t: {halted,exception,data_ram_write} expected 000, got %b",
                 $time, $sampled({halted, exception, data_ram_write}));
    end

    store_address: assert property (@(posedge clock) disable iff (!reset_n)
        data_ram_write && run && store_index < store_count
            |-> data_ram_address == expected_address[store_index]
    ) else begin
        errors++;
        $display("Mismatch at %0t: data_ram_address expected %h, got %h", $time,
                 $sampled(expected_address[store_index]), $sampled(data_ram_address));
    end

    store_data: assert property (@(posedge clock) disable iff (!reset_n)
        data_ram_write && run && store_index < store_count
            |-> data_ram_write_data == expected_data[store_index]
    ) else begin
        errors++;
        $display("Mismatch at %0t: data_ram_write_data expected %h, got %h", $time,
                 $sampled(expected_data[store_index]), $sampled(data_ram_write_data));
    end

    store_expected: assert property (@(posedge clock) disable iff (!reset_n)
        data_ram_write && run |-> store_index < store_count
    ) else begin
        errors++;
        $display("unexpected store to address %h at %0t", $sampled(data_ram_address), $time);
    end

    fetch_not_skipped: assert property (@(posedge clock) disable iff (!reset_n)
        !skipped[inst_ram_address[9:2]]
    ) else begin
        errors++;
        $display("fetch from skipped address %h at %0t", $sampled(inst_ram_address), $time);
    end

    frozen_outputs: assert property (@(posedge clock) disable iff (!reset_n)
        !run |=> $stable({inst_ram_address, data_ram_write, halted})
    ) else begin
        errors++;
        $display("outputs changed while run was low at %0t", $time);
    end

    halt_exception: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(halted) |-> exception == expect_exception
    ) else begin
        errors++;
        $display("Mismatch at %0t: exception expected %b, got %b",
                 $time, $sampled(expect_exception), $sampled(exception));
    end

    quiet_after_halt: assert property (@(posedge clock) disable iff (!reset_n)
        halted |-> !data_ram_write
    ) else begin
        errors++;
        $display("store issued after the core halted at %0t", $time);
    end

    task automatic emit(input word_t word);
        mem.inst_array[program_length] = word;
        program_length++;
    endtask

    // reference semantics of the RV32I integer operations
    function automatic word_t arith(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic write_model(input reg_addr_t rd, input word_t value);
        if (rd != 5'd0) begin
            model_reg[rd] = value;
        end
    endtask

    task automatic register_op(input logic [6:0] f7, input logic [2:0] f3,
                               input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
        emit({f7, rs2, rs1, f3, rd, opcode_alu_reg});
        write_model(rd, arith(f3, f7[5], model_reg[rs1], model_reg[rs2]));
    endtask

    task automatic immediate_op(input logic [2:0] f3, input reg_addr_t rd,
                                input reg_addr_t rs1, input logic [11:0] imm);
        emit({imm, rs1, f3, rd, opcode_alu_imm});
        // srai is flagged by bit 10 of the immediate
        write_model(rd, arith(f3, f3 == 3'd5 && imm[10], model_reg[rs1],
                              {{20{imm[11]}}, imm}));
    endtask

    task automatic load_upper(input reg_addr_t rd, input logic [19:0] upper);
        emit({upper, rd, opcode_lui});
        write_model(rd, {upper, 12'h000});
    endtask

    task automatic set_reg(input reg_addr_t rd, input word_t value);
        word_t adjusted;
        // addi sign-extends, so round the upper part up
        adjusted = value + 32'h800;
        load_upper(rd, adjusted[31:12]);
        immediate_op(3'd0, rd, rd, value[11:0]);
    endtask

    task automatic store_reg(input reg_addr_t rs2);
        logic [11:0] offset;
        offset = 12'(store_base + 4 * store_count);
        emit({offset[11:5], rs2, 5'd0, 3'b010, offset[4:0], opcode_store});
        expected_address[store_count] = address_width'(store_base + 4 * store_count);
        expected_data[store_count]    = model_reg[rs2];
        store_count++;
    endtask

    // a store to 0x3fc that must never be fetched
    task automatic poison();
        skipped[program_length] = 1'b1;
        emit({7'h1f, 5'd1, 5'd0, 3'b010, 5'h1c, opcode_store});
    endtask

    task automatic branch(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2);
        logic  taken;
        word_t a;
        word_t b;
        a = model_reg[rs1];
        b = model_reg[rs2];
        case (f3)
            3'd0:    taken = a == b;
            3'd1:    taken = a != b;
            3'd4:    taken = $signed(a) < $signed(b);
            3'd5:    taken = $signed(a) >= $signed(b);
            3'd6:    taken = a < b;
            default: taken = a >= b;
        endcase
        // offset 8 jumps over the next word
        emit({1'b0, 6'd0, rs2, rs1, f3, 4'd4, 1'b0, opcode_branch});
        if (taken) begin
            poison();
        end else begin
            store_reg(rs1);
        end
    endtask

    task automatic assemble_program();
        logic [11:0] imm;
        word_t       target;
        set_reg(1, $random(seed));
        set_reg(2, $random(seed));
        for (int f = 0; f < 8; f++) begin
            register_op(7'h00, 3'(f), 5, 1, 2);
            store_reg(5);
        end
        register_op(7'h20, 3'd0, 5, 1, 2);
        store_reg(5);
        register_op(7'h20, 3'd5, 5, 1, 2);
        store_reg(5);
        for (int f = 0; f < 8; f++) begin
            imm = 12'($random(seed));
            if (f == 1 || f == 5) begin
                imm[11:5] = 7'h00;
            end
            immediate_op(3'(f), 6, 1, imm);
            store_reg(6);
        end
        imm[11:5] = 7'h20;
        immediate_op(3'd5, 6, 1, imm);
        store_reg(6);
        load_upper(10, 20'($random(seed)));
        store_reg(10);
        // a write to x0 must leave it zero
        immediate_op(3'd0, 0, 1, 12'h123);
        store_reg(0);
        // read back the first stored result and store it again
        emit({12'(store_base), 5'd0, 3'b010, 5'd11, opcode_load});
        write_model(11, expected_data[0]);
        store_reg(11);
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                branch(3'(f), 1, 2);
                branch(3'(f), 2, 1);
            end
        end
        write_model(7, word_t'(4 * program_length + 4));
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd7, opcode_jal});
        poison();
        store_reg(7);
        // jalr target gets an odd offset, the core clears bit 0
        target = word_t'(4 * (program_length + 3));
        immediate_op(3'd0, 8, 0, target[11:0]);
        write_model(9, word_t'(4 * program_length + 4));
        emit({12'd1, 5'd8, 3'd0, 5'd9, opcode_jalr});
        poison();
        store_reg(9);
        emit({12'd1, 5'd0, 3'd0, 5'd0, opcode_system});
        poison();
    endtask

    initial begin
        seed             = 32'h00eecc3e;
        reset_n          = 1'b0;
        run              = 1'b1;
        expect_exception = 1'b0;
        for (int i = 0; i < 256; i++) begin
            skipped[i] = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            model_reg[i] = '0;
        end
        @(negedge clock);
        assemble_program();
        cycle_limit = 4 * (7 * program_length + gap_cycles);
        repeat (2) @(negedge clock);
        reset_n = 1'b1;
        // freeze the core partway through the program
        repeat (150) @(negedge clock);
        run = 1'b0;
        repeat (gap_cycles) @(negedge clock);
        run = 1'b1;
        while (!halted) begin
            @(negedge clock);
        end
        repeat (5) @(negedge clock);
        all_stores_seen: assert (store_index == store_count)
            else begin
                errors++;
                $display("only %0d of %0d expected stores were seen", store_index, store_count);
            end
        // restart with an illegal word at address 0
        reset_n          = 1'b0;
        expect_exception = 1'b1;
        mem.inst_array[0] = 32'hffff_ffff;
        repeat (3) @(negedge clock);
        reset_n = 1'b1;
        while (!halted) begin
            @(negedge clock);
        end
        repeat (2) @(negedge clock);
        $display("errors: %0d, stores checked: %0d of %0d", errors, store_index, store_count);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim.f
hw/core_pkg.sv
hw/reg_port_if.sv
hw/register_file.sv
hw/decoder.sv
hw/alu.sv
hw/control_fsm.sv
hw/shader_core.sv
tests/data_memory.sv
tests/tb_shader_core.sv

// File: run.sh
#!/usr/bin/env bash
# build the shader core testbench with Verilator, run it and check the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f sim.f \
    --top-module tb_shader_core \
    -Mdir "$build_dir" \
    -o tb_shader_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_shader_core" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$log_file"; then
    exit 0
fi
exit 1
